// ==== include/ex_stage_config.svh ====
/*
 * execute stage configuration
 * datapath width, tag width, multiplier depth and completion queue size
 */
`ifndef EX_STAGE_CONFIG_SVH
`define EX_STAGE_CONFIG_SVH

// datapath
`define XLEN             32
`define TAG_BITS         6   // physical register tag

// multiplier pipe, each stage eats 2*XLEN/MULT_STAGES multiplier bits
`define MULT_STAGES      4

// completion queue entries, keep a power of two
`define COMPLETION_DEPTH 8

`endif

// ==== source/ex_stage_pkg.sv ====
/*
 * execute stage types
 * unit and opcode enums, operand selects, the issue packet
 * and the completion record shared by every unit
 */
`include "ex_stage_config.svh"

package ex_stage_pkg;

	typedef enum logic [1:0] {
		ALU,
		MULT,
		BRANCH
	} exec_unit_t;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
		ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA
	} alu_func_t;

	typedef enum logic [1:0] {
		MUL, MULH, MULHSU, MULHU
	} mult_func_t;

	typedef enum logic [1:0] {
		OPA_IS_RS1, OPA_IS_NPC, OPA_IS_PC, OPA_IS_ZERO
	} opa_select_t;

	typedef enum logic [2:0] {
		OPB_IS_RS2, OPB_IS_I_IMM, OPB_IS_S_IMM,
		OPB_IS_B_IMM, OPB_IS_U_IMM, OPB_IS_J_IMM
	} opb_select_t;

	// one issued instruction, branch function comes from inst funct3
	typedef struct packed {
		logic                 valid;
		exec_unit_t           unit;
		alu_func_t            alu_func;
		mult_func_t           mult_func;
		opa_select_t          opa_select;
		opb_select_t          opb_select;
		logic                 cond_branch;
		logic                 uncond_branch;
		logic [31:0]          inst;
		logic [`XLEN-1:0]     pc;
		logic [`XLEN-1:0]     npc;
		logic [`XLEN-1:0]     rs1_value;
		logic [`XLEN-1:0]     rs2_value;
		logic [`TAG_BITS-1:0] dest_tag;
	} issue_packet_t;

	typedef struct packed {
		logic                 valid;
		logic [`TAG_BITS-1:0] tag;
		logic [`XLEN-1:0]     value;
	} completion_t;

endpackage

// ==== source/operand_select.sv ====
/*
 * operand select
 * picks operand A and operand B for the ALU and branch unit,
 * decoding the RV32 immediates out of the instruction word
 */
`timescale 1ns/1ps
`include "ex_stage_config.svh"

module operand_select (
	input  ex_stage_pkg::issue_packet_t packet,
	output logic [`XLEN-1:0]           operand_a,
	output logic [`XLEN-1:0]           operand_b
);
	import ex_stage_pkg::*;

	logic [31:0] inst;
	logic [`XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;

	assign inst = packet.inst;

	//////////////////// immediates
	assign imm_i = {{21{inst[31]}}, inst[30:20]};
	assign imm_s = {{21{inst[31]}}, inst[30:25], inst[11:7]};
	assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {inst[31:12], 12'b0};
	assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

	//////////////////// muxes
	always_comb begin
		case (packet.opa_select)
			OPA_IS_RS1:  operand_a = packet.rs1_value;
			OPA_IS_NPC:  operand_a = packet.npc;
			OPA_IS_PC:   operand_a = packet.pc;
			OPA_IS_ZERO: operand_a = '0;
			default:     operand_a = `XLEN'hdeadfbac; // bad select marker
		endcase
	end

	always_comb begin
		case (packet.opb_select)
			OPB_IS_RS2:   operand_b = packet.rs2_value;
			OPB_IS_I_IMM: operand_b = imm_i;
			OPB_IS_S_IMM: operand_b = imm_s;
			OPB_IS_B_IMM: operand_b = imm_b;
			OPB_IS_U_IMM: operand_b = imm_u;
			OPB_IS_J_IMM: operand_b = imm_j;
			default:      operand_b = `XLEN'hfacefeed; // 6, 7 are unused codes
		endcase
	end

endmodule

// ==== source/alu.sv ====
/*
 * integer ALU
 * one-cycle registered result for ALU-class instructions,
 * link value for jumps issued here
 */
`timescale 1ns/1ps
`include "ex_stage_config.svh"

module alu (
	input                               clock,
	input                               reset,
	input  ex_stage_pkg::issue_packet_t packet,
	input  logic [`XLEN-1:0]           operand_a,
	input  logic [`XLEN-1:0]           operand_b,
	output ex_stage_pkg::completion_t   alu_done
);
	import ex_stage_pkg::*;

	logic start;
	logic [`XLEN-1:0] result;
	logic signed [`XLEN-1:0] signed_a, signed_b;

	assign start    = packet.valid && (packet.unit == ALU);
	assign signed_a = operand_a;
	assign signed_b = operand_b;

	always_comb begin
		case (packet.alu_func)
			ALU_ADD:  result = operand_a + operand_b;
			ALU_SUB:  result = operand_a - operand_b;
			ALU_AND:  result = operand_a & operand_b;
			ALU_OR:   result = operand_a | operand_b;
			ALU_XOR:  result = operand_a ^ operand_b;
			ALU_SLT:  result = `XLEN'(signed_a < signed_b);
			ALU_SLTU: result = `XLEN'(operand_a < operand_b);
			ALU_SLL:  result = operand_a << operand_b[4:0];
			ALU_SRL:  result = operand_a >> operand_b[4:0];
			ALU_SRA:  result = signed_a >>> operand_b[4:0]; // keeps the sign
			default:  result = `XLEN'hfacebeec;
		endcase
		if (packet.uncond_branch)
			result = packet.npc; // jal/jalr write the return address
	end

	always_ff @(posedge clock) begin
		if (reset)
			alu_done.valid <= 1'b0;
		else
			alu_done.valid <= start;
		alu_done.tag   <= packet.dest_tag;
		alu_done.value <= result;
	end

endmodule

// ==== source/multiplier.sv ====
/*
 * pipelined multiplier
 * MULT_STAGES register stages, each adding one slice of partial
 * product; function, tag and valid ride along with the data
 */
`timescale 1ns/1ps
`include "ex_stage_config.svh"

module multiplier (
	input                               clock,
	input                               reset,
	input  ex_stage_pkg::issue_packet_t packet,
	output ex_stage_pkg::completion_t   mult_done
);
	import ex_stage_pkg::*;

	localparam int STAGES = `MULT_STAGES;
	localparam int SLICE  = 2 * `XLEN / `MULT_STAGES; // multiplier bits per stage

	logic [1:0] sign; // {rs2, rs1} signed
	logic [2*`XLEN-1:0] product [STAGES+1];
	logic [2*`XLEN-1:0] mcand   [STAGES];
	logic [2*`XLEN-1:0] mplier  [STAGES];
	logic               stage_valid [STAGES+1];
	logic [`TAG_BITS-1:0] stage_tag [STAGES+1];
	mult_func_t         stage_func  [STAGES+1];

	always_comb begin
		case (packet.mult_func)
			MULHSU:  sign = 2'b01;
			MULHU:   sign = 2'b00;
			default: sign = 2'b11; // MUL, MULH
		endcase
	end

	// stage 0 is the issue packet itself
	assign product[0]     = '0;
	assign mcand[0]       = sign[0] ? {{`XLEN{packet.rs1_value[`XLEN-1]}}, packet.rs1_value}
	                                : {{`XLEN{1'b0}}, packet.rs1_value};
	assign mplier[0]      = sign[1] ? {{`XLEN{packet.rs2_value[`XLEN-1]}}, packet.rs2_value}
	                                : {{`XLEN{1'b0}}, packet.rs2_value};
	assign stage_valid[0] = packet.valid && (packet.unit == MULT);
	assign stage_tag[0]   = packet.dest_tag;
	assign stage_func[0]  = packet.mult_func;

	for (genvar i = 0; i < STAGES; i++) begin : g_stage
		always_ff @(posedge clock) begin
			if (reset)
				stage_valid[i+1] <= 1'b0;
			else
				stage_valid[i+1] <= stage_valid[i];
			stage_tag[i+1]  <= stage_tag[i];
			stage_func[i+1] <= stage_func[i];
			product[i+1]    <= product[i] + mplier[i][SLICE-1:0] * mcand[i];
		end

		if (i < STAGES - 1) begin : g_shift // last stage needs no shifted operands
			always_ff @(posedge clock) begin
				mcand[i+1]  <= mcand[i] << SLICE;
				mplier[i+1] <= mplier[i] >> SLICE;
			end
		end
	end

	always_comb begin
		mult_done.valid = stage_valid[STAGES];
		mult_done.tag   = stage_tag[STAGES];
		if (stage_func[STAGES] == MUL)
			mult_done.value = product[STAGES][`XLEN-1:0];
		else
			mult_done.value = product[STAGES][2*`XLEN-1:`XLEN]; // high word
	end

endmodule

// ==== source/branch_unit.sv ====
/*
 * branch unit
 * evaluates the branch condition, adds the target and
 * registers take_branch and target one cycle after issue
 */
`timescale 1ns/1ps
`include "ex_stage_config.svh"

module branch_unit (
	input                               clock,
	input                               reset,
	input  ex_stage_pkg::issue_packet_t packet,
	input  logic [`XLEN-1:0]           operand_a,
	input  logic [`XLEN-1:0]           operand_b,
	output ex_stage_pkg::completion_t   branch_done,
	output logic                        branch_valid,
	output logic                        take_branch,
	output logic [`XLEN-1:0]           branch_target
);
	import ex_stage_pkg::*;

	logic start, cond, take;
	logic signed [`XLEN-1:0] signed_rs1, signed_rs2;

	assign start      = packet.valid && (packet.unit == BRANCH);
	assign signed_rs1 = packet.rs1_value;
	assign signed_rs2 = packet.rs2_value;

	always_comb begin
		case (packet.inst[14:12]) // funct3
			3'b000:  cond = packet.rs1_value == packet.rs2_value; // beq
			3'b001:  cond = packet.rs1_value != packet.rs2_value; // bne
			3'b100:  cond = signed_rs1 < signed_rs2;              // blt
			3'b101:  cond = signed_rs1 >= signed_rs2;             // bge
			3'b110:  cond = packet.rs1_value < packet.rs2_value;  // bltu
			3'b111:  cond = packet.rs1_value >= packet.rs2_value; // bgeu
			default: cond = 1'b0;
		endcase
	end

	assign take = packet.uncond_branch | (packet.cond_branch & cond);

	always_ff @(posedge clock) begin
		if (reset) begin
			branch_valid      <= 1'b0;
			take_branch       <= 1'b0;
			branch_done.valid <= 1'b0;
		end else begin
			branch_valid      <= start;
			take_branch       <= start && take;
			branch_done.valid <= start;
		end
		branch_target     <= operand_a + operand_b;
		branch_done.tag   <= packet.dest_tag;
		branch_done.value <= packet.uncond_branch ? packet.npc : '0; // link value
	end

endmodule

// ==== source/completion_arbiter.sv ====
/*
 * completion arbiter
 * queues unit results in a circular buffer, mult then branch then ALU,
 * and drives one registered completion per cycle
 */
`timescale 1ns/1ps
`include "ex_stage_config.svh"

module completion_arbiter (
	input                             clock,
	input                             reset,
	input  ex_stage_pkg::completion_t mult_done,
	input  ex_stage_pkg::completion_t branch_done,
	input  ex_stage_pkg::completion_t alu_done,
	output ex_stage_pkg::completion_t complete
);
	import ex_stage_pkg::*;

	localparam int DEPTH    = `COMPLETION_DEPTH;
	localparam int PTR_BITS = $clog2(DEPTH);

	completion_t queue [DEPTH];
	completion_t ins   [3];          // push order
	logic [PTR_BITS-1:0] head, tail, tail_next;
	logic [PTR_BITS-1:0] slot [3];
	logic [PTR_BITS:0]   count, level;
	logic [2:0]          accept;
	logic                pop;

	assign ins[0] = mult_done;
	assign ins[1] = branch_done;
	assign ins[2] = alu_done;
	assign pop    = (count != '0);

	//////////////////// push
	// pointers wrap on their own, depth is a power of two
	always_comb begin
		tail_next = tail;
		level     = count;
		accept    = '0;
		for (int i = 0; i < 3; i++) begin
			slot[i] = tail_next;
			if (ins[i].valid && (level < DEPTH)) begin // full drops it
				accept[i] = 1'b1;
				tail_next = tail_next + 1'b1;
				level     = level + 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		for (int i = 0; i < 3; i++)
			if (accept[i])
				queue[slot[i]] <= ins[i];
	end

	//////////////////// pop
	always_ff @(posedge clock) begin
		if (reset) begin
			head           <= '0;
			tail           <= '0;
			count          <= '0;
			complete.valid <= 1'b0;
		end else begin
			head           <= head + PTR_BITS'(pop);
			tail           <= tail_next;
			count          <= level - (PTR_BITS+1)'(pop);
			complete.valid <= pop;
		end
		complete.tag   <= queue[head].tag;
		complete.value <= queue[head].value;
	end

endmodule

// ==== source/ex_stage.sv ====
/*
 * execute stage top
 * operand select feeding ALU, multiplier and branch unit,
 * all sharing one completion bus through the arbiter
 */
`timescale 1ns/1ps
`include "ex_stage_config.svh"

module ex_stage (
	input                               clock,
	input                               reset,
	input  ex_stage_pkg::issue_packet_t issue,
	output ex_stage_pkg::completion_t   complete,
	output logic                        branch_valid,
	output logic                        take_branch,
	output logic [`XLEN-1:0]           branch_target
);
	import ex_stage_pkg::*;

	logic [`XLEN-1:0] operand_a, operand_b;
	completion_t alu_done, mult_done, branch_done;

	operand_select opsel (.packet(issue), .operand_a(operand_a), .operand_b(operand_b));

	//////////////////// units
	alu alu0 (
		.clock(clock), .reset(reset), .packet(issue),
		.operand_a(operand_a), .operand_b(operand_b),
		.alu_done(alu_done)
	);

	multiplier mult0 (.clock(clock), .reset(reset), .packet(issue), .mult_done(mult_done));

	branch_unit br0 (
		.clock(clock), .reset(reset), .packet(issue),
		.operand_a(operand_a), .operand_b(operand_b),
		.branch_done(branch_done), .branch_valid(branch_valid),
		.take_branch(take_branch), .branch_target(branch_target)
	);

	completion_arbiter arb (
		.clock(clock), .reset(reset),
		.mult_done(mult_done), .branch_done(branch_done), .alu_done(alu_done),
		.complete(complete)
	);

endmodule

// ==== testbench/ex_stage_checker.sv ====
/*
 * execute stage assertions
 * completion queue overflow and empty pops, branch pulse rules
 */
`timescale 1ns/1ps
`include "ex_stage_config.svh"

module ex_stage_checker (
	input                                 clock,
	input                                 reset,
	input                                 push_dropped,
	input [$clog2(`COMPLETION_DEPTH):0]   queue_count,
	input [$clog2(`COMPLETION_DEPTH)-1:0] head_ptr,
	input [$clog2(`COMPLETION_DEPTH)-1:0] tail_ptr,
	input                                 complete_valid,
	input                                 branch_valid,
	input                                 take_branch
);
	int failures = 0; // read by the testbench

	no_push_when_full: assert property (@(posedge clock) disable iff (reset)
		!push_dropped)
		else begin
			$error("completion pushed while the queue was full");
			failures++;
		end

	take_needs_valid: assert property (@(posedge clock) disable iff (reset)
		take_branch |-> branch_valid)
		else begin
			$error("take_branch high without branch_valid");
			failures++;
		end

	// pointers apart, or wrapped all the way round when full
	no_pop_from_empty: assert property (@(posedge clock) disable iff (reset)
		complete_valid |-> $past(head_ptr != tail_ptr || queue_count == `COMPLETION_DEPTH))
		else begin
			$error("completion presented from an empty queue");
			failures++;
		end

endmodule

bind completion_arbiter ex_stage_checker arb_rules (
	.clock(clock), .reset(reset),
	.push_dropped((mult_done.valid & ~accept[0]) | (branch_done.valid & ~accept[1])
		| (alu_done.valid & ~accept[2])),
	.queue_count(count), .head_ptr(head), .tail_ptr(tail),
	.complete_valid(complete.valid),
	.branch_valid(1'b0), .take_branch(1'b0)
);

bind branch_unit ex_stage_checker branch_rules (
	.clock(clock), .reset(reset),
	.push_dropped(1'b0), .queue_count('1), .head_ptr('0), .tail_ptr('0),
	.complete_valid(1'b0),
	.branch_valid(branch_valid), .take_branch(take_branch)
);

// ==== testbench/ex_stage_monitor.sv ====
/*
 * execute stage monitor
 * checks every completion against the value expected for its tag
 * and every branch pulse one cycle after a branch issue
 */
`timescale 1ns/1ps
`include "ex_stage_config.svh"

module ex_stage_monitor (
	input                               clock,
	input                               reset,
	input  ex_stage_pkg::issue_packet_t issue,
	input  ex_stage_pkg::completion_t   complete,
	input                               branch_valid,
	input                               take_branch,
	input  [`XLEN-1:0]                  branch_target
);
	import ex_stage_pkg::*;

	logic [`XLEN-1:0] exp_value [1<<`TAG_BITS];
	bit               pending   [1<<`TAG_BITS];
	int outstanding = 0;
	int value_errors = 0;
	int protocol_errors = 0;
	bit next_take, armed, armed_take;
	logic [`XLEN-1:0] next_target, armed_target;

	task expect_completion(input logic [`TAG_BITS-1:0] tag, input logic [`XLEN-1:0] value);
		exp_value[tag] = value;
		pending[tag]   = 1'b1;
		outstanding++;
	endtask

	task expect_branch(input bit take, input logic [`XLEN-1:0] target);
		next_take   = take;
		next_target = target;
	endtask

	task report_missing();
		for (int t = 0; t < (1<<`TAG_BITS); t++)
			if (pending[t]) begin
				$display("tag %0d never completed", t);
				protocol_errors++;
			end
	endtask

	always @(posedge clock) begin
		if (reset) begin
			armed = 1'b0;
		end else begin
			if (complete.valid) begin
				if (!pending[complete.tag]) begin
					$display("at %0t tag %0d completed while not outstanding", $time, complete.tag);
					protocol_errors++;
				end else begin
					pending[complete.tag] = 1'b0;
					outstanding--;
					if (complete.value !== exp_value[complete.tag]) begin
						$display("[FAIL] %0t complete.value (tag %0d) expected %h actual %h",
							$time, complete.tag, exp_value[complete.tag], complete.value);
						value_errors++;
					end
				end
			end
			//////////////////// branch pulse
			if (armed) begin
				if (branch_valid !== 1'b1 || take_branch !== armed_take) begin
					$display("[FAIL] %0t take_branch expected %b actual %b (branch_valid %b)",
						$time, armed_take, take_branch, branch_valid);
					value_errors++;
				end
				if (branch_target !== armed_target) begin
					$display("[FAIL] %0t branch_target expected %h actual %h",
						$time, armed_target, branch_target);
					value_errors++;
				end
			end else if (branch_valid || take_branch) begin
				$display("at %0t a branch pulse appeared with no branch issued", $time);
				protocol_errors++;
			end
			armed        = issue.valid && issue.unit == BRANCH;
			armed_take   = next_take;
			armed_target = next_target;
		end
	end

endmodule

// ==== testbench/ex_stage_tb.sv ====
/*
 * execute stage testbench
 * table of issue packets with expected results, applied back to back
 */
`timescale 1ns/1ps
`include "ex_stage_config.svh"

module ex_stage_tb;
	import ex_stage_pkg::*;

	logic clock = 1'b0;
	logic reset = 1'b1;
	issue_packet_t issue = '0;
	completion_t complete;
	logic branch_valid, take_branch;
	logic [`XLEN-1:0] branch_target;

	issue_packet_t    rows [$];
	logic [`XLEN-1:0] exp_value [$];
	logic [`XLEN-1:0] exp_target [$];
	bit               exp_take [$];
	integer seed = 32'hccd0_9800;
	int cycles = 0;
	int limit, asserts;

	logic [2:0] branch_inst_codes [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};

	ex_stage uut (.clock(clock), .reset(reset), .issue(issue), .complete(complete),
		.branch_valid(branch_valid), .take_branch(take_branch), .branch_target(branch_target));

	ex_stage_monitor mon (.clock(clock), .reset(reset), .issue(issue), .complete(complete),
		.branch_valid(branch_valid), .take_branch(take_branch), .branch_target(branch_target));

	always #10 clock = ~clock;
	always @(posedge clock) cycles++;

	//////////////////// reference rules
	function automatic logic [31:0] operand_a_of(issue_packet_t p);
		case (p.opa_select)
			OPA_IS_RS1: return p.rs1_value;
			OPA_IS_NPC: return p.npc;
			OPA_IS_PC:  return p.pc;
			default:    return 32'h0;
		endcase
	endfunction

	function automatic logic [31:0] operand_b_of(issue_packet_t p);
		logic [31:0] i;
		i = p.inst;
		case (p.opb_select)
			OPB_IS_I_IMM: return {{20{i[31]}}, i[31:20]};
			OPB_IS_S_IMM: return {{20{i[31]}}, i[31:25], i[11:7]};
			OPB_IS_B_IMM: return {{19{i[31]}}, i[31], i[7], i[30:25], i[11:8], 1'b0};
			OPB_IS_U_IMM: return {i[31:12], 12'h000};
			OPB_IS_J_IMM: return {{11{i[31]}}, i[31], i[19:12], i[20], i[30:21], 1'b0};
			default:      return p.rs2_value;
		endcase
	endfunction

	function automatic logic [31:0] alu_result(alu_func_t f, logic [31:0] a, logic [31:0] b);
		case (f)
			ALU_ADD:  return a + b;
			ALU_SUB:  return a - b;
			ALU_AND:  return a & b;
			ALU_OR:   return a | b;
			ALU_XOR:  return a ^ b;
			ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
			ALU_SLL:  return a << b[4:0];
			ALU_SRL:  return a >> b[4:0];
			default:  return $signed(a) >>> b[4:0];
		endcase
	endfunction

	function automatic logic [31:0] mult_result(mult_func_t f, logic [31:0] a, logic [31:0] b);
		logic [63:0] wide_a, wide_b, product;
		wide_a  = (f == MULHU) ? {32'h0, a} : {{32{a[31]}}, a};
		wide_b  = (f == MULHU || f == MULHSU) ? {32'h0, b} : {{32{b[31]}}, b};
		product = wide_a * wide_b;
		return (f == MUL) ? product[31:0] : product[63:32];
	endfunction

	function automatic bit branch_holds(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
		case (f3)
			3'b000:  return a == b;
			3'b001:  return a != b;
			3'b100:  return $signed(a) < $signed(b);
			3'b101:  return $signed(a) >= $signed(b);
			3'b110:  return a < b;
			default: return a >= b;
		endcase
	endfunction

	// build one row, tag is the row number
	task add_row(exec_unit_t unit, alu_func_t af, mult_func_t mf, opa_select_t sa,
		opb_select_t sb, bit uncond, logic [31:0] inst, logic [31:0] rs1, logic [31:0] rs2);
		issue_packet_t p;
		p = '0;
		p.valid = 1'b1;
		p.unit = unit;
		p.alu_func = af;
		p.mult_func = mf;
		p.opa_select = sa;
		p.opb_select = sb;
		p.cond_branch = (unit == BRANCH) && !uncond;
		p.uncond_branch = uncond;
		p.inst = inst;
		p.pc = 32'h0000_1000 + 32'(rows.size() * 4);
		p.npc = p.pc + 32'd4;
		p.rs1_value = rs1;
		p.rs2_value = rs2;
		p.dest_tag = `TAG_BITS'(rows.size());
		rows.push_back(p);
		exp_target.push_back(operand_a_of(p) + operand_b_of(p));
		exp_take.push_back(uncond || (p.cond_branch && branch_holds(inst[14:12], rs1, rs2)));
		if (unit == MULT)
			exp_value.push_back(mult_result(mf, rs1, rs2));
		else if (uncond)
			exp_value.push_back(p.npc);
		else if (unit == BRANCH)
			exp_value.push_back(32'h0);
		else
			exp_value.push_back(alu_result(af, operand_a_of(p), operand_b_of(p)));
	endtask

	function automatic logic [31:0] branch_inst(logic [2:0] f3);
		return {7'b1111110, 10'h0, f3, 5'b10101, 7'h63}; // backward offset
	endfunction

	initial begin
		for (int f = 0; f < 10; f++)
			add_row(ALU, alu_func_t'(f), MUL, OPA_IS_RS1, OPB_IS_RS2, 0, 32'h0,
				32'h8000_0f13 + 32'(f), 32'h0000_0005 + 32'(f));
		add_row(ALU, ALU_ADD, MUL, OPA_IS_NPC, OPB_IS_I_IMM, 0, 32'hf9c1_2093, 0, 0);
		add_row(ALU, ALU_XOR, MUL, OPA_IS_PC, OPB_IS_S_IMM, 0, 32'h8a52_3da3, 0, 0);
		add_row(ALU, ALU_OR, MUL, OPA_IS_ZERO, OPB_IS_U_IMM, 0, 32'hdead_b0b7, 0, 0);
		add_row(ALU, ALU_SUB, MUL, OPA_IS_RS1, OPB_IS_B_IMM, 0, 32'hfe5a_8ae3, 32'h77, 0);
		add_row(ALU, ALU_ADD, MUL, OPA_IS_RS1, OPB_IS_J_IMM, 0, 32'h8c3f_f0ef, 32'h100, 0);
		add_row(ALU, ALU_ADD, MUL, OPA_IS_RS1, OPB_IS_I_IMM, 1, 32'h0040_8067, 32'h20, 0);
		// back-to-back multiplies, the last one lands with an ALU issue
		add_row(MULT, ALU_ADD, MUL, OPA_IS_RS1, OPB_IS_RS2, 0, 0, 32'hffff_fffd, 32'd7);
		add_row(MULT, ALU_ADD, MULH, OPA_IS_RS1, OPB_IS_RS2, 0, 0, 32'hffff_fffd, 32'd7);
		add_row(MULT, ALU_ADD, MULH, OPA_IS_RS1, OPB_IS_RS2, 0, 0, 32'h8000_0000, 32'h8000_0000);
		add_row(MULT, ALU_ADD, MULHSU, OPA_IS_RS1, OPB_IS_RS2, 0, 0, 32'hffff_ffff, 32'hffff_ffff);
		add_row(MULT, ALU_ADD, MULHU, OPA_IS_RS1, OPB_IS_RS2, 0, 0, 32'hffff_ffff, 32'hffff_ffff);
		add_row(MULT, ALU_ADD, MULHSU, OPA_IS_RS1, OPB_IS_RS2, 0, 0, 32'h9234_5678, 32'h9abc_def0);
		add_row(ALU, ALU_SLL, MUL, OPA_IS_RS1, OPB_IS_RS2, 0, 0, 32'h0000_00ff, 32'd12);
		add_row(ALU, ALU_SRA, MUL, OPA_IS_RS1, OPB_IS_RS2, 0, 0, 32'hf000_0000, 32'd7);
		add_row(ALU, ALU_SLT, MUL, OPA_IS_RS1, OPB_IS_RS2, 0, 0, 32'hffff_fff0, 32'd1);
		//////////////////// branches, equal operands then unequal ones
		foreach (branch_inst_codes[k]) begin
			add_row(BRANCH, ALU_ADD, MUL, OPA_IS_PC, OPB_IS_B_IMM, 0,
				branch_inst(branch_inst_codes[k]), 32'hffff_fff0, 32'hffff_fff0);
			if (k == 2 || k == 3) // blt and bge want rs1 below rs2 signed
				add_row(BRANCH, ALU_ADD, MUL, OPA_IS_PC, OPB_IS_B_IMM, 0,
					branch_inst(branch_inst_codes[k]), 32'hffff_fff0, 32'h0000_0003);
			else
				add_row(BRANCH, ALU_ADD, MUL, OPA_IS_PC, OPB_IS_B_IMM, 0,
					branch_inst(branch_inst_codes[k]), 32'h0000_0003, 32'hffff_fffe);
		end
		add_row(BRANCH, ALU_ADD, MUL, OPA_IS_PC, OPB_IS_J_IMM, 1, 32'h7f0f_f06f, 0, 0);
		for (int r = 0; r < 8; r++)
			add_row(ALU, alu_func_t'($unsigned($random(seed)) % 10), MUL, OPA_IS_RS1,
				OPB_IS_RS2, 0, 0, $random(seed), $random(seed));
		limit = rows.size() * (`MULT_STAGES + `COMPLETION_DEPTH + 4);

		repeat (4) @(posedge clock);
		#1 reset = 1'b0;
		repeat (3) @(posedge clock); // quiet after reset
		foreach (rows[i]) begin
			@(posedge clock);
			#1;
			issue = rows[i];
			mon.expect_completion(rows[i].dest_tag, exp_value[i]);
			if (rows[i].unit == BRANCH)
				mon.expect_branch(exp_take[i], exp_target[i]);
		end
		@(posedge clock);
		#1 issue = '0;
		while (mon.outstanding != 0 && cycles < limit)
			@(posedge clock);
		repeat (2) @(posedge clock);
		if (mon.outstanding != 0)
			$display("timeout after %0d cycles, %0d completions outstanding",
				cycles, mon.outstanding);
		mon.report_missing();
		asserts = uut.arb.arb_rules.failures + uut.br0.branch_rules.failures;
		$display("value errors %0d, protocol errors %0d, assertion failures %0d",
			mon.value_errors, mon.protocol_errors, asserts);
		if (mon.value_errors + mon.protocol_errors + asserts == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// ==== ex_stage.f ====
+incdir+include
source/ex_stage_pkg.sv
source/operand_select.sv
source/alu.sv
source/multiplier.sv
source/branch_unit.sv
source/completion_arbiter.sv
source/ex_stage.sv
testbench/ex_stage_checker.sv
testbench/ex_stage_monitor.sv
testbench/ex_stage_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the execute stage testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f ex_stage.f \
	--top-module ex_stage_tb -o sim_ex_stage &&
out=$(./obj_dir/sim_ex_stage +verilator+error+limit+1000) ; echo "$out" ;
echo "$out" | grep -q "Finished with no errors" && echo "simulation passed" ||
{ echo "simulation failed" ; exit 1 ; }
